// File: Bender.yml
package:
  name: nic_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/nic_csr_pkg.sv
      - verilog/nic_rpc_pkg.sv
      - verilog/nic_csr.sv
      - verilog/nic_rpc_path.sv
      - verilog/nic_perf_counters.sv
      - verilog/nic_top.sv
  - target: test
    include_dirs:
      - verilog
      - test
    files:
      - test/nic_tb.sv

// File: nic_ctrl.f
+incdir+verilog
+incdir+test
verilog/nic_csr_pkg.sv
verilog/nic_rpc_pkg.sv
verilog/nic_csr.sv
verilog/nic_rpc_path.sv
verilog/nic_perf_counters.sv
verilog/nic_top.sv
test/nic_tb.sv

// File: test/nic_tb_tasks.svh
// ====================
// Stimulus and check tasks, included inside nic_tb
// All driving happens on the falling edge of ccip_clk
// ====================
`ifndef NIC_TB_TASKS_SVH
`define NIC_TB_TASKS_SVH

localparam int WAIT_LIMIT = 100;

task automatic check_value(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    if (got !== exp) begin
        $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("Test failures found");
        $fatal(1, "Mismatch on %s", name);
    end
endtask

task automatic timeout_fail(input string what);
    $display("Timed out waiting for %s", what);
    $display("Test failures found");
    $fatal(1, "Wait limit reached");
endtask

task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
    @(negedge ccip_clk);
    mmio_wr_valid = 1'b1;
    mmio_addr     = addr;
    mmio_wr_data  = data;
    @(negedge ccip_clk);
    mmio_wr_valid = 1'b0;
endtask

// Random tid per read, the response is expected to echo it
task automatic mmio_read(input logic [15:0] addr, output logic [63:0] data);
    int          cycles;
    logic [31:0] r;
    cycles = 0;
    r      = $random(seed);
    @(negedge ccip_clk);
    mmio_rd_valid = 1'b1;
    mmio_addr     = addr;
    mmio_tid      = r[`NIC_MMIO_TID_WIDTH-1:0];
    @(negedge ccip_clk);
    mmio_rd_valid = 1'b0;
    while (!mmio_rsp_valid) begin
        if (cycles == WAIT_LIMIT) begin
            timeout_fail("MMIO read response");
        end
        @(negedge ccip_clk);
        cycles++;
    end
    data = mmio_rsp_data;
endtask

task automatic drain_egress();
    int cycles;
    cycles = 0;
    @(negedge ccip_clk);
    host_tx_ready = 1'b1;
    while (to_host_valid) begin
        if (cycles == WAIT_LIMIT) begin
            timeout_fail("egress FIFO to drain");
        end
        @(negedge ccip_clk);
        cycles++;
    end
    host_tx_ready = 1'b0;
endtask

`endif

// File: test/nic_tb.sv
// ====================
// Testbench for nic_top with a 64-cycle RPS window
// Shadow model is updated and compared on the rising edge
// ====================
`timescale 1ns/1ps
`include "nic_defs.svh"

module nic_tb;

    localparam int RPS_WINDOW = 64;
    localparam int FIFO_DEPTH = 2 ** `NIC_RPC_FIFO_LDEPTH;
    localparam logic [63:0] DFH_VALUE = 64'h1000_0100_0000_0000;
    localparam logic [127:0] AFU_ID = `NIC_AFU_ID;

    logic                               ccip_clk;
    logic                               reset;
    logic                               mmio_rd_valid;
    logic                               mmio_wr_valid;
    logic [`NIC_MMIO_ADDR_WIDTH-1:0]    mmio_addr;
    logic [`NIC_MMIO_TID_WIDTH-1:0]     mmio_tid;
    logic [`NIC_MMIO_DATA_WIDTH-1:0]    mmio_wr_data;
    logic                               mmio_rsp_valid;
    logic [`NIC_MMIO_TID_WIDTH-1:0]     mmio_rsp_tid;
    logic [`NIC_MMIO_DATA_WIDTH-1:0]    mmio_rsp_data;
    logic [`NIC_CL_ADDR_WIDTH-1:0]      mem_tx_addr;
    logic [`NIC_CL_ADDR_WIDTH-1:0]      mem_rx_addr;
    logic                               nic_start;
    logic [`NIC_LMAX_NUM_OF_FLOWS-1:0]  num_of_flows;
    logic                               nic_init;
    logic [`NIC_LMAX_RX_QUEUE_SIZE-1:0] rx_queue_size;
    logic [`NIC_LMAX_TX_BATCH-1:0]      tx_batch_size;
    logic                               ccip_initialized;
    logic                               ccip_error;
    logic                               host_rpc_valid;
    nic_rpc_pkg::rpc_word_t             host_rpc_word;
    logic                               net_tx_valid;
    nic_rpc_pkg::rpc_word_t             net_tx_word;
    logic                               net_rx_valid;
    nic_rpc_pkg::rpc_word_t             net_rx_word;
    logic                               host_tx_ready;
    logic                               to_host_valid;
    nic_rpc_pkg::rpc_word_t             to_host_word;

    integer seed = 32'h93a7;

    // ====================
    // Shadow model
    // ====================
    logic [63:0]                        cnt_model [4];
    nic_rpc_pkg::rpc_word_t             fifo_model [$];
    logic                               tx_valid_model;
    nic_rpc_pkg::rpc_word_t             tx_word_model;
    logic                               rsp_pending;
    logic [`NIC_MMIO_TID_WIDTH-1:0]     rsp_tid_model;
    logic [63:0]                        rsp_data_model;
    nic_csr_pkg::nic_status_t           status_model;
    nic_csr_pkg::pck_cnt_sel_e          sel_model;
    logic                               start_model;
    logic                               ovf_model;
    logic                               rpc_q_model;
    int                                 window_model;
    logic [31:0]                        req_model;
    logic [31:0]                        rps_model;

    `include "nic_tb_tasks.svh"

    nic_top #(
        .RPS_WINDOW(RPS_WINDOW)
    ) nic_top_inst (.*);

    initial begin
        ccip_clk = 1'b0;
        forever #4 ccip_clk = ~ccip_clk;
    end

    // Expected read data from the model state before this edge
    function automatic logic [63:0] expected_read(input logic [15:0] addr);
        case (addr)
            nic_csr_pkg::DFH:        return DFH_VALUE;
            nic_csr_pkg::AFU_ID_L:   return AFU_ID[63:0];
            nic_csr_pkg::AFU_ID_H:   return AFU_ID[127:64];
            nic_csr_pkg::NIC_STATUS: return 64'(status_model);
            nic_csr_pkg::CCIP_RPS:   return 64'(rps_model);
            nic_csr_pkg::PCK_CNT:    return cnt_model[sel_model];
            nic_csr_pkg::CCIP_MODE:  return 64'(nic_csr_pkg::QUEUE_POLLING);
            default:                 return 64'h0;
        endcase
    endfunction

    function automatic nic_rpc_pkg::rpc_word_t random_word();
        nic_rpc_pkg::rpc_word_t w;
        logic [31:0]            r;
        r         = $random(seed);
        w.flow_id = r[`NIC_LMAX_NUM_OF_FLOWS-1:0];
        w.data    = {$random(seed), $random(seed)};
        return w;
    endfunction

    // ====================
    // Compare process
    // ====================
    always @(posedge ccip_clk) begin
        logic full_model;
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                cnt_model[i] = '0;
            end
            fifo_model.delete();
            tx_valid_model = 1'b0;
            rsp_pending    = 1'b0;
            status_model   = '{nic_id: `NIC_ID_VALUE, default: 1'b0};
            sel_model      = nic_csr_pkg::IN_RPC;
            start_model    = 1'b0;
            ovf_model      = 1'b0;
            rpc_q_model    = 1'b0;
            window_model   = 0;
            req_model      = '0;
            rps_model      = '0;
        end else begin
            check_value("mmio_rsp_valid", mmio_rsp_valid, rsp_pending);
            if (rsp_pending) begin
                check_value("mmio_rsp_tid", mmio_rsp_tid, rsp_tid_model);
                check_value("mmio_rsp_data", mmio_rsp_data, rsp_data_model);
            end
            check_value("net_tx_valid", net_tx_valid, tx_valid_model);
            if (tx_valid_model) begin
                check_value("net_tx_word", net_tx_word, tx_word_model);
            end
            check_value("to_host_valid", to_host_valid, fifo_model.size() != 0);

            rsp_pending = mmio_rd_valid;
            if (mmio_rd_valid) begin
                rsp_tid_model  = mmio_tid;
                rsp_data_model = expected_read(mmio_addr);
            end
            // Status takes its inputs one cycle late
            status_model.ready           = ccip_initialized;
            status_model.running         = ccip_initialized & start_model;
            status_model.err_rx_fifo_ovf = ovf_model;
            status_model.err_ccip        = ccip_error;
            status_model.error           = ovf_model | ccip_error;

            cnt_model[0] = cnt_model[0] + 64'(host_rpc_valid);
            cnt_model[2] = cnt_model[2] + 64'(tx_valid_model);
            cnt_model[3] = cnt_model[3] + 64'(net_rx_valid);
            tx_valid_model = host_rpc_valid;
            tx_word_model  = host_rpc_word;

            // Full is judged before this cycle's pop
            full_model = (fifo_model.size() == FIFO_DEPTH);
            if (fifo_model.size() != 0 && host_tx_ready) begin
                check_value("to_host_word", to_host_word, fifo_model[0]);
                void'(fifo_model.pop_front());
                cnt_model[1] = cnt_model[1] + 64'd1;
            end
            if (net_rx_valid && full_model) begin
                ovf_model = 1'b1;
            end else if (net_rx_valid) begin
                fifo_model.push_back(net_rx_word);
            end

            if (window_model == RPS_WINDOW - 1) begin
                rps_model    = req_model + 32'(rpc_q_model);
                req_model    = '0;
                window_model = 0;
            end else begin
                req_model    = req_model + 32'(rpc_q_model);
                window_model = window_model + 1;
            end
            rpc_q_model = host_rpc_valid;

            if (mmio_wr_valid && mmio_addr == nic_csr_pkg::NIC_START) begin
                start_model = mmio_wr_data[0];
            end
            if (mmio_wr_valid && mmio_addr == nic_csr_pkg::GET_PCK_CNT) begin
                sel_model = nic_csr_pkg::pck_cnt_sel_e'(mmio_wr_data[1:0]);
            end
        end
    end

    // ====================
    // Test sequence
    // ====================
    initial begin
        logic [63:0] rsp;
        logic [63:0] wdata;
        logic [31:0] r;
        reset            = 1'b1;
        mmio_rd_valid    = 1'b0;
        mmio_wr_valid    = 1'b0;
        mmio_addr        = '0;
        mmio_tid         = '0;
        mmio_wr_data     = '0;
        ccip_initialized = 1'b0;
        ccip_error       = 1'b0;
        host_rpc_valid   = 1'b0;
        host_rpc_word    = '0;
        net_rx_valid     = 1'b0;
        net_rx_word      = '0;
        host_tx_ready    = 1'b0;
        repeat (4) @(posedge ccip_clk);
        @(negedge ccip_clk);
        reset = 1'b0;

        // Identity words and an unmapped address
        mmio_read(nic_csr_pkg::DFH, rsp);
        mmio_read(nic_csr_pkg::AFU_ID_L, rsp);
        mmio_read(nic_csr_pkg::AFU_ID_H, rsp);
        mmio_read(nic_csr_pkg::RSVD0, rsp);
        mmio_read(16'h0100, rsp);
        mmio_read(nic_csr_pkg::CCIP_MODE, rsp);

        // Configuration outputs
        wdata = {$random(seed), $random(seed)};
        mmio_write(nic_csr_pkg::MEM_TX_ADDR, wdata);
        check_value("mem_tx_addr", mem_tx_addr, wdata[`NIC_CL_ADDR_WIDTH-1:0]);
        wdata = {$random(seed), $random(seed)};
        mmio_write(nic_csr_pkg::MEM_RX_ADDR, wdata);
        check_value("mem_rx_addr", mem_rx_addr, wdata[`NIC_CL_ADDR_WIDTH-1:0]);
        mmio_write(nic_csr_pkg::NUM_OF_FLOWS, 64'd5);
        check_value("num_of_flows", num_of_flows, 3'd4);
        mmio_write(nic_csr_pkg::RX_QUEUE_SIZE, 64'd6);
        check_value("rx_queue_size", rx_queue_size, 3'd5);
        mmio_write(nic_csr_pkg::TX_BATCH_SIZE, 64'd2);
        check_value("tx_batch_size", tx_batch_size, 2'd2);
        check_value("nic_init", nic_init, 1'b0);
        mmio_write(nic_csr_pkg::INIT, 64'h0);
        check_value("nic_init", nic_init, 1'b1);

        // Engine comes up, then start
        ccip_initialized = 1'b1;
        mmio_write(nic_csr_pkg::NIC_START, 64'd1);
        check_value("nic_start", nic_start, 1'b1);
        mmio_read(nic_csr_pkg::NIC_STATUS, rsp);
        check_value("status ready", rsp[4], 1'b1);
        check_value("status running", rsp[3], 1'b1);
        ccip_error = 1'b1;
        mmio_read(nic_csr_pkg::NIC_STATUS, rsp);
        check_value("status err_ccip", rsp[1], 1'b1);
        check_value("status error", rsp[0], 1'b1);
        ccip_error = 1'b0;

        // Host words to the network side
        repeat (40) begin
            @(negedge ccip_clk);
            r              = $random(seed);
            host_rpc_valid = r[0];
            host_rpc_word  = random_word();
        end
        @(negedge ccip_clk);
        host_rpc_valid = 1'b0;

        // Network words to the host with random back-pressure
        repeat (80) begin
            @(negedge ccip_clk);
            r             = $random(seed);
            net_rx_valid  = r[0] & r[1];
            net_rx_word   = random_word();
            host_tx_ready = r[2] | r[3];
        end
        @(negedge ccip_clk);
        net_rx_valid = 1'b0;
        drain_egress();

        // Nine pushes into a stalled FIFO, the ninth is lost
        repeat (FIFO_DEPTH + 1) begin
            @(negedge ccip_clk);
            net_rx_valid = 1'b1;
            net_rx_word  = random_word();
        end
        @(negedge ccip_clk);
        net_rx_valid = 1'b0;
        mmio_read(nic_csr_pkg::NIC_STATUS, rsp);
        check_value("status err_rx_fifo_ovf", rsp[2], 1'b1);
        drain_egress();

        // Requests stay on so IN_RPC runs one ahead of NET_TX
        @(negedge ccip_clk);
        host_rpc_valid = 1'b1;

        // Every counter select
        for (int sel = 0; sel < 4; sel++) begin
            mmio_write(nic_csr_pkg::GET_PCK_CNT, 64'(sel));
            mmio_read(nic_csr_pkg::PCK_CNT, rsp);
        end

        // Requests on every cycle for over three windows
        repeat (3 * RPS_WINDOW + 16) begin
            @(negedge ccip_clk);
            host_rpc_word = random_word();
        end
        mmio_read(nic_csr_pkg::CCIP_RPS, rsp);
        check_value("rps_value", rsp, 64'(RPS_WINDOW));
        host_rpc_valid = 1'b0;
        repeat (4) @(negedge ccip_clk);

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: verilog/nic_csr.sv
// ====================
// MMIO CSR block with one-cycle read responses
// A read gets exactly one response, unmapped addresses read zero
// CCI-P mode is fixed to queue polling
// ====================
`timescale 1ns/1ps
`include "nic_defs.svh"

module nic_csr (
    input  logic                                 ccip_clk,
    input  logic                                 reset,
    // MMIO request
    input  logic                                 mmio_rd_valid,
    input  logic                                 mmio_wr_valid,
    input  logic [`NIC_MMIO_ADDR_WIDTH-1:0]      mmio_addr,
    input  logic [`NIC_MMIO_TID_WIDTH-1:0]       mmio_tid,
    input  logic [`NIC_MMIO_DATA_WIDTH-1:0]      mmio_wr_data,
    // MMIO response
    output logic                                 mmio_rsp_valid,
    output logic [`NIC_MMIO_TID_WIDTH-1:0]       mmio_rsp_tid,
    output logic [`NIC_MMIO_DATA_WIDTH-1:0]      mmio_rsp_data,
    // Configuration to the CCI-P engine
    output logic [`NIC_CL_ADDR_WIDTH-1:0]        mem_tx_addr,
    output logic [`NIC_CL_ADDR_WIDTH-1:0]        mem_rx_addr,
    output logic                                 nic_start,
    output logic [`NIC_LMAX_NUM_OF_FLOWS-1:0]    num_of_flows,
    output logic                                 nic_init,
    output logic [`NIC_LMAX_RX_QUEUE_SIZE-1:0]   rx_queue_size,
    output logic [`NIC_LMAX_TX_BATCH-1:0]        tx_batch_size,
    // Engine and data path status
    input  logic                                 ccip_initialized,
    input  logic                                 ccip_error,
    input  logic                                 rx_fifo_ovf,
    // Counters
    input  logic [31:0]                          rps_value,
    input  logic [63:0]                          pck_cnt_value,
    output nic_csr_pkg::pck_cnt_sel_e            pck_cnt_sel
);

    // AFU type in the top nibble, end-of-list at bit 40
    localparam logic [`NIC_MMIO_DATA_WIDTH-1:0] DFH_VALUE = 64'h1000_0100_0000_0000;
    localparam logic [127:0] AFU_ID = `NIC_AFU_ID;

    nic_csr_pkg::nic_status_t         nic_status;
    logic [`NIC_MMIO_DATA_WIDTH-1:0]  rd_data;

    // ====================
    // Write decode
    // ====================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            mem_tx_addr   <= '0;
            mem_rx_addr   <= '0;
            nic_start     <= 1'b0;
            num_of_flows  <= '0;
            nic_init      <= 1'b0;
            rx_queue_size <= '0;
            tx_batch_size <= '0;
            pck_cnt_sel   <= nic_csr_pkg::IN_RPC;
        end else if (mmio_wr_valid) begin
            case (mmio_addr)
                nic_csr_pkg::MEM_TX_ADDR: mem_tx_addr <= mmio_wr_data[`NIC_CL_ADDR_WIDTH-1:0];
                nic_csr_pkg::MEM_RX_ADDR: mem_rx_addr <= mmio_wr_data[`NIC_CL_ADDR_WIDTH-1:0];
                nic_csr_pkg::NIC_START:   nic_start   <= mmio_wr_data[0];
                // Engine expects count minus one
                nic_csr_pkg::NUM_OF_FLOWS: begin
                    num_of_flows <= mmio_wr_data[`NIC_LMAX_NUM_OF_FLOWS-1:0] - 1'b1;
                end
                // Any write starts init, data ignored
                nic_csr_pkg::INIT: nic_init <= 1'b1;
                nic_csr_pkg::GET_PCK_CNT: begin
                    pck_cnt_sel <= nic_csr_pkg::pck_cnt_sel_e'(mmio_wr_data[1:0]);
                end
                nic_csr_pkg::RX_QUEUE_SIZE: begin
                    rx_queue_size <= mmio_wr_data[`NIC_LMAX_RX_QUEUE_SIZE-1:0] - 1'b1;
                end
                nic_csr_pkg::TX_BATCH_SIZE: begin
                    tx_batch_size <= mmio_wr_data[`NIC_LMAX_TX_BATCH-1:0];
                end
                default: ;
            endcase
        end
    end

    // ====================
    // Status register
    // ====================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            nic_status <= '{nic_id: `NIC_ID_VALUE, default: 1'b0};
        end else begin
            nic_status.nic_id          <= `NIC_ID_VALUE;
            nic_status.ready           <= ccip_initialized;
            nic_status.running         <= ccip_initialized & nic_start;
            nic_status.err_rx_fifo_ovf <= rx_fifo_ovf;
            nic_status.err_ccip        <= ccip_error;
            nic_status.error           <= rx_fifo_ovf | ccip_error;
        end
    end

    // ====================
    // Read path
    // ====================
    always_comb begin
        case (mmio_addr)
            nic_csr_pkg::DFH:        rd_data = DFH_VALUE;
            nic_csr_pkg::AFU_ID_L:   rd_data = AFU_ID[63:0];
            nic_csr_pkg::AFU_ID_H:   rd_data = AFU_ID[127:64];
            nic_csr_pkg::NIC_STATUS: rd_data = 64'(nic_status);
            nic_csr_pkg::CCIP_RPS:   rd_data = 64'(rps_value);
            nic_csr_pkg::PCK_CNT:    rd_data = pck_cnt_value;
            nic_csr_pkg::CCIP_MODE:  rd_data = 64'(nic_csr_pkg::QUEUE_POLLING);
            // Reserved DFH words and all write-only CSRs
            default:                 rd_data = '0;
        endcase
    end

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            mmio_rsp_valid <= 1'b0;
        end else begin
            mmio_rsp_valid <= mmio_rd_valid;
        end
    end

    // Response payload only moves with a read
    always_ff @(posedge ccip_clk) begin
        if (mmio_rd_valid) begin
            mmio_rsp_tid  <= mmio_tid;
            mmio_rsp_data <= rd_data;
        end
    end

endmodule

// File: verilog/nic_csr_pkg.sv
// ====================
// CSR map and CSR-side types
// Addresses count 32-bit words, so 64-bit registers sit on even addresses
// ====================
`include "nic_defs.svh"

package nic_csr_pkg;

    // ====================
    // Address map
    // ====================
    typedef enum logic [15:0] {
        // Device feature header block
        DFH           = 16'h0000,
        AFU_ID_L      = 16'h0002,
        AFU_ID_H      = 16'h0004,
        RSVD0         = 16'h0006,
        RSVD1         = 16'h0008,
        // NIC registers
        MEM_TX_ADDR   = `NIC_CSR_BASE + 16'd0,
        MEM_RX_ADDR   = `NIC_CSR_BASE + 16'd2,
        NIC_START     = `NIC_CSR_BASE + 16'd4,
        NUM_OF_FLOWS  = `NIC_CSR_BASE + 16'd6,
        INIT          = `NIC_CSR_BASE + 16'd8,
        NIC_STATUS    = `NIC_CSR_BASE + 16'd10,
        CCIP_RPS      = `NIC_CSR_BASE + 16'd12,
        GET_PCK_CNT   = `NIC_CSR_BASE + 16'd14,
        PCK_CNT       = `NIC_CSR_BASE + 16'd16,
        CCIP_MODE     = `NIC_CSR_BASE + 16'd18,
        RX_QUEUE_SIZE = `NIC_CSR_BASE + 16'd22,
        TX_BATCH_SIZE = `NIC_CSR_BASE + 16'd24
    } csr_addr_e;

    // Packet counter selection, written through GET_PCK_CNT
    typedef enum logic [1:0] {
        IN_RPC  = 2'd0,
        OUT_RPC = 2'd1,
        NET_TX  = 2'd2,
        NET_RX  = 2'd3
    } pck_cnt_sel_e;

    typedef enum logic [1:0] {
        MMIO          = 2'd0,
        POLLING       = 2'd1,
        DMA           = 2'd2,
        QUEUE_POLLING = 2'd3
    } ccip_mode_e;

    // Status readback, 9 bits, nic_id on top
    typedef struct packed {
        logic [3:0] nic_id;
        logic       ready;
        logic       running;
        logic       err_rx_fifo_ovf;
        logic       err_ccip;
        logic       error;
    } nic_status_t;

endpackage

// File: verilog/nic_defs.svh
// ====================
// Widths, depths and identity constants shared by RTL and testbench
// NIC_CSR_BASE must stay clear of the feature header at 0x0000..0x0008
// ====================
`ifndef NIC_DEFS_SVH
`define NIC_DEFS_SVH

// Configuration field widths
`define NIC_LMAX_NUM_OF_FLOWS 3
`define NIC_LMAX_RX_QUEUE_SIZE 3
`define NIC_LMAX_TX_BATCH 2

// RPC data path
`define NIC_RPC_FIFO_LDEPTH 3
`define NIC_RPC_DATA_WIDTH 64

// MMIO and CCI-P widths
`define NIC_MMIO_ADDR_WIDTH 16
`define NIC_MMIO_DATA_WIDTH 64
`define NIC_MMIO_TID_WIDTH 9
`define NIC_CL_ADDR_WIDTH 42

// MMIO address of the first NIC CSR, in 32-bit words
`define NIC_CSR_BASE 16'h0020

// Identity
`define NIC_AFU_ID 128'h5c2b_7e1d_9a34_4f60_b8e1_0c7d_3a96_f245
`define NIC_ID_VALUE 4'd0

`endif

// File: verilog/nic_perf_counters.sv
// ====================
// Request rate over a window of RPS_WINDOW cycles, plus packet counters
// rps_value reads zero until the first window has closed
// ====================
`timescale 1ns/1ps

module nic_perf_counters #(
    parameter int RPS_WINDOW = 400000000
) (
    input  logic                      ccip_clk,
    input  logic                      reset,
    // Events
    input  logic                      host_rpc_valid,
    input  logic                      egress_pop,
    input  logic                      net_tx_valid,
    input  logic                      net_rx_valid,
    // Readback
    input  nic_csr_pkg::pck_cnt_sel_e pck_cnt_sel,
    output logic [31:0]               rps_value,
    output logic [63:0]               pck_cnt_value
);

    logic        host_rpc_valid_q;
    logic [31:0] window_cnt;
    logic [31:0] req_cnt;
    logic [3:0]  events;
    logic [63:0] pck_cnt [4];

    // ====================
    // RPS
    // ====================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            host_rpc_valid_q <= 1'b0;
            window_cnt       <= '0;
            req_cnt          <= '0;
            rps_value        <= '0;
        end else begin
            host_rpc_valid_q <= host_rpc_valid;
            if (window_cnt == 32'(RPS_WINDOW - 1)) begin
                // Last cycle of the window still counts
                rps_value  <= req_cnt + 32'(host_rpc_valid_q);
                req_cnt    <= '0;
                window_cnt <= '0;
            end else begin
                req_cnt    <= req_cnt + 32'(host_rpc_valid_q);
                window_cnt <= window_cnt + 1'b1;
            end
        end
    end

    // ====================
    // Packet counters
    // ====================
    // Bit order follows pck_cnt_sel_e
    assign events = {net_rx_valid, net_tx_valid, egress_pop, host_rpc_valid};

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                pck_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (events[i]) begin
                    pck_cnt[i] <= pck_cnt[i] + 1'b1;
                end
            end
        end
    end

    // CSR block registers this on read
    assign pck_cnt_value = pck_cnt[pck_cnt_sel];

endmodule

// File: verilog/nic_rpc_path.sv
// ====================
// Host to network register stage and network to host FIFO
// A push into a full FIFO is dropped, even with a pop in the same cycle
// ====================
`timescale 1ns/1ps
`include "nic_defs.svh"

module nic_rpc_path (
    input  logic                   ccip_clk,
    input  logic                   reset,
    // Host ingress
    input  logic                   host_rpc_valid,
    input  nic_rpc_pkg::rpc_word_t host_rpc_word,
    // Network transmit
    output logic                   net_tx_valid,
    output nic_rpc_pkg::rpc_word_t net_tx_word,
    // Network receive
    input  logic                   net_rx_valid,
    input  nic_rpc_pkg::rpc_word_t net_rx_word,
    // Host egress
    input  logic                   host_tx_ready,
    output logic                   to_host_valid,
    output nic_rpc_pkg::rpc_word_t to_host_word,
    output logic                   egress_pop,
    output logic                   rx_fifo_ovf
);

    localparam int DEPTH = 2 ** `NIC_RPC_FIFO_LDEPTH;

    nic_rpc_pkg::rpc_word_t            fifo_mem [DEPTH];
    logic [`NIC_RPC_FIFO_LDEPTH-1:0]   wr_ptr;
    logic [`NIC_RPC_FIFO_LDEPTH-1:0]   rd_ptr;
    logic [`NIC_RPC_FIFO_LDEPTH:0]     count;
    logic                              full;
    logic                              push;

    // ====================
    // Ingress stage
    // ====================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            net_tx_valid <= 1'b0;
        end else begin
            net_tx_valid <= host_rpc_valid;
        end
    end

    always_ff @(posedge ccip_clk) begin
        net_tx_word <= host_rpc_word;
    end

    // ====================
    // Egress FIFO
    // ====================
    assign full          = (count == DEPTH);
    assign push          = net_rx_valid & ~full;
    assign to_host_valid = (count != '0);
    // Show-ahead, head word is always on the output
    assign to_host_word  = fifo_mem[rd_ptr];
    assign egress_pop    = to_host_valid & host_tx_ready;

    always_ff @(posedge ccip_clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= net_rx_word;
        end
    end

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            rx_fifo_ovf <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (egress_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, egress_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // Sticky until reset
            if (net_rx_valid && full) begin
                rx_fifo_ovf <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/nic_rpc_pkg.sv
// ====================
// RPC word as carried between host and network
// No header or framing, one word per valid strobe
// ====================
`include "nic_defs.svh"

package nic_rpc_pkg;

    // ====================
    // RPC word
    // ====================
    // flow_id sits above the payload
    typedef struct packed {
        logic [`NIC_LMAX_NUM_OF_FLOWS-1:0] flow_id;
        logic [`NIC_RPC_DATA_WIDTH-1:0]    data;
    } rpc_word_t;

endpackage

// File: verilog/nic_top.sv
// ====================
// F-NIC top, single ccip_clk domain
// The CCI-P engine sits outside and is driven by the configuration outputs
// ====================
`timescale 1ns/1ps
`include "nic_defs.svh"

module nic_top #(
    parameter int RPS_WINDOW = 400000000
) (
    input  logic                               ccip_clk,
    input  logic                               reset,
    // MMIO
    input  logic                               mmio_rd_valid,
    input  logic                               mmio_wr_valid,
    input  logic [`NIC_MMIO_ADDR_WIDTH-1:0]    mmio_addr,
    input  logic [`NIC_MMIO_TID_WIDTH-1:0]     mmio_tid,
    input  logic [`NIC_MMIO_DATA_WIDTH-1:0]    mmio_wr_data,
    output logic                               mmio_rsp_valid,
    output logic [`NIC_MMIO_TID_WIDTH-1:0]     mmio_rsp_tid,
    output logic [`NIC_MMIO_DATA_WIDTH-1:0]    mmio_rsp_data,
    // CCI-P engine
    output logic [`NIC_CL_ADDR_WIDTH-1:0]      mem_tx_addr,
    output logic [`NIC_CL_ADDR_WIDTH-1:0]      mem_rx_addr,
    output logic                               nic_start,
    output logic [`NIC_LMAX_NUM_OF_FLOWS-1:0]  num_of_flows,
    output logic                               nic_init,
    output logic [`NIC_LMAX_RX_QUEUE_SIZE-1:0] rx_queue_size,
    output logic [`NIC_LMAX_TX_BATCH-1:0]      tx_batch_size,
    input  logic                               ccip_initialized,
    input  logic                               ccip_error,
    // RPC data path
    input  logic                               host_rpc_valid,
    input  nic_rpc_pkg::rpc_word_t             host_rpc_word,
    output logic                               net_tx_valid,
    output nic_rpc_pkg::rpc_word_t             net_tx_word,
    input  logic                               net_rx_valid,
    input  nic_rpc_pkg::rpc_word_t             net_rx_word,
    input  logic                               host_tx_ready,
    output logic                               to_host_valid,
    output nic_rpc_pkg::rpc_word_t             to_host_word
);

    logic                      rx_fifo_ovf;
    logic                      egress_pop;
    logic [31:0]               rps_value;
    logic [63:0]               pck_cnt_value;
    nic_csr_pkg::pck_cnt_sel_e pck_cnt_sel;

    nic_csr nic_csr_inst (
        .ccip_clk, .reset,
        .mmio_rd_valid, .mmio_wr_valid, .mmio_addr, .mmio_tid, .mmio_wr_data,
        .mmio_rsp_valid, .mmio_rsp_tid, .mmio_rsp_data,
        .mem_tx_addr, .mem_rx_addr, .nic_start, .num_of_flows, .nic_init,
        .rx_queue_size, .tx_batch_size,
        .ccip_initialized, .ccip_error, .rx_fifo_ovf,
        .rps_value, .pck_cnt_value, .pck_cnt_sel
    );

    nic_rpc_path nic_rpc_path_inst (
        .ccip_clk, .reset,
        .host_rpc_valid, .host_rpc_word, .net_tx_valid, .net_tx_word,
        .net_rx_valid, .net_rx_word,
        .host_tx_ready, .to_host_valid, .to_host_word, .egress_pop, .rx_fifo_ovf
    );

    nic_perf_counters #(
        .RPS_WINDOW(RPS_WINDOW)
    ) nic_perf_counters_inst (
        .ccip_clk, .reset,
        .host_rpc_valid, .egress_pop, .net_tx_valid, .net_rx_valid,
        .pck_cnt_sel, .rps_value, .pck_cnt_value
    );

endmodule
